/* common/kbd_params.svh */
`ifndef KBD_PARAMS_SVH
`define KBD_PARAMS_SVH

// Number of event FIFO entries (a power of two)
`define KBD_FIFO_DEPTH 8

// Flops in the ps2_clk / ps2_data synchroniser
`define KBD_SYNC_STAGES 3

`endif

/* common/ps2_pkg.sv */
package ps2_pkg;

    // One byte from the keyboard
    typedef logic [7:0] scan_code_t;

    // Bit position within the 11-bit frame
    typedef logic [3:0] bit_count_t;

    localparam scan_code_t PS2_BREAK_PREFIX = 8'hF0; // Key released
    localparam scan_code_t PS2_EXT_PREFIX   = 8'hE0; // Extended key set

    localparam bit_count_t PS2_LAST_BIT = 4'd10; // Stop bit position

endpackage

/* common/key_pkg.sv */
package key_pkg;

    typedef logic [7:0] ascii_t;

    // Stored event as {code, ascii, release, extended}
    typedef logic [17:0] key_word_t;

    // Prefix tracking in the event decoder
    typedef enum logic [1:0] {
        dec_idle,      // No prefix seen
        dec_ext,       // After E0
        dec_break,     // After F0
        dec_ext_break  // After E0 F0
    } dec_state_t;

endpackage

/* ps2_rx/ps2_frame_rx.sv */
`timescale 1ns/1ps
`include "kbd_params.svh"

module ps2_frame_rx import ps2_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output scan_code_t code,
    output logic       code_valid,
    output logic       frame_error
);

    localparam int SYNC = `KBD_SYNC_STAGES;

    logic [SYNC-1:0] clk_sync;
    logic [SYNC-1:0] data_sync;
    logic [9:0]      frame_bits; // Start, 8 data, parity
    bit_count_t      bit_count;
    logic            fall;
    logic            rx_bit;
    logic            frame_ok;

    // Both lines idle high, so reset to ones to avoid a false edge
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[SYNC-2:0], ps2_clk};
            data_sync <= {data_sync[SYNC-2:0], ps2_data};
        end
    end

    assign fall   = clk_sync[SYNC-1] & ~clk_sync[SYNC-2]; // Falling edge of ps2_clk
    assign rx_bit = data_sync[SYNC-1];                    // Last sample before the edge

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame_bits[0] & rx_bit & (^frame_bits[9:1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_count <= '0;
        end else if (fall) begin
            if (bit_count == PS2_LAST_BIT) begin
                bit_count <= '0; // Restart for the next frame
            end else begin
                bit_count <= bit_count + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall && bit_count != PS2_LAST_BIT) begin
            frame_bits[bit_count] <= rx_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            code_valid <= fall && bit_count == PS2_LAST_BIT && frame_ok;
            if (fall && bit_count == PS2_LAST_BIT && !frame_ok) begin
                frame_error <= 1'b1; // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall && bit_count == PS2_LAST_BIT) begin
            code <= frame_bits[8:1];
        end
    end

    // A frame takes many clk cycles, so a valid never repeats back to back
    a_single_pulse: assert property (
        @(posedge clk) disable iff (rst) code_valid |=> !code_valid
    );

endmodule

/* source/key_event_decoder.sv */
`timescale 1ns/1ps

module key_event_decoder import ps2_pkg::*, key_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  scan_code_t code,
    input  logic       code_valid,
    output scan_code_t ev_code,
    output logic       ev_release,
    output logic       ev_extended,
    output logic       ev_valid
);

    dec_state_t state;
    logic       is_break;
    logic       is_ext;

    assign is_break = (code == PS2_BREAK_PREFIX);
    assign is_ext   = (code == PS2_EXT_PREFIX);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= dec_idle;
            ev_valid <= 1'b0;
        end else begin
            ev_valid <= code_valid && !is_break && !is_ext;
            if (code_valid) begin
                if (is_ext) begin
                    state <= dec_ext;
                end else if (is_break) begin
                    // E0 F0 keeps the extended flag
                    if (state == dec_ext || state == dec_ext_break) begin
                        state <= dec_ext_break;
                    end else begin
                        state <= dec_break;
                    end
                end else begin
                    state <= dec_idle; // Sequence complete
                end
            end
        end
    end

    // Flags are taken from the prefix state when the key byte lands
    always_ff @(posedge clk) begin
        if (code_valid && !is_break && !is_ext) begin
            ev_code     <= code;
            ev_release  <= (state == dec_break) || (state == dec_ext_break);
            ev_extended <= (state == dec_ext) || (state == dec_ext_break);
        end
    end

    a_no_prefix_event: assert property (
        @(posedge clk) disable iff (rst)
        ev_valid |-> (ev_code != PS2_BREAK_PREFIX && ev_code != PS2_EXT_PREFIX)
    );

endmodule

/* source/ascii_map.sv */
`timescale 1ns/1ps

module ascii_map import ps2_pkg::*, key_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  scan_code_t ev_code,
    input  logic       ev_release,
    input  logic       ev_extended,
    input  logic       ev_valid,
    output scan_code_t map_code,
    output ascii_t     map_ascii,
    output logic       map_release,
    output logic       map_extended,
    output logic       map_valid
);

    ascii_t lookup;

    // Set 2 scan codes for letters and digits
    always_comb begin
        case (ev_code)
            8'h1C: lookup = 8'h41; // A
            8'h32: lookup = 8'h42;
            8'h21: lookup = 8'h43;
            8'h23: lookup = 8'h44;
            8'h24: lookup = 8'h45;
            8'h2B: lookup = 8'h46;
            8'h34: lookup = 8'h47;
            8'h33: lookup = 8'h48;
            8'h43: lookup = 8'h49;
            8'h3B: lookup = 8'h4A;
            8'h42: lookup = 8'h4B;
            8'h4B: lookup = 8'h4C;
            8'h3A: lookup = 8'h4D;
            8'h31: lookup = 8'h4E;
            8'h44: lookup = 8'h4F;
            8'h4D: lookup = 8'h50;
            8'h15: lookup = 8'h51;
            8'h2D: lookup = 8'h52;
            8'h1B: lookup = 8'h53;
            8'h2C: lookup = 8'h54;
            8'h3C: lookup = 8'h55;
            8'h2A: lookup = 8'h56;
            8'h1D: lookup = 8'h57;
            8'h22: lookup = 8'h58;
            8'h35: lookup = 8'h59;
            8'h1A: lookup = 8'h5A; // Z
            8'h45: lookup = 8'h30; // 0
            8'h16: lookup = 8'h31;
            8'h1E: lookup = 8'h32;
            8'h26: lookup = 8'h33;
            8'h25: lookup = 8'h34;
            8'h2E: lookup = 8'h35;
            8'h36: lookup = 8'h36;
            8'h3D: lookup = 8'h37;
            8'h3E: lookup = 8'h38;
            8'h46: lookup = 8'h39; // 9
            default: lookup = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            map_valid <= 1'b0;
        end else begin
            map_valid <= ev_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ev_valid) begin
            map_code     <= ev_code;
            map_ascii    <= ev_extended ? 8'h00 : lookup; // E0 keys share codes with letters
            map_release  <= ev_release;
            map_extended <= ev_extended;
        end
    end

endmodule

/* source/key_fifo.sv */
`timescale 1ns/1ps
`include "kbd_params.svh"

module key_fifo import ps2_pkg::*, key_pkg::*; #(
    parameter int DEPTH = `KBD_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       rst,
    input  scan_code_t map_code,
    input  ascii_t     map_ascii,
    input  logic       map_release,
    input  logic       map_extended,
    input  logic       map_valid,
    input  logic       key_next,
    output scan_code_t key_code,
    output ascii_t     key_ascii,
    output logic       key_release,
    output logic       key_extended,
    output logic       key_ready,
    output logic       overflow
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = DEPTH[AW:0];

    key_word_t       mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;
    logic            full;
    logic            push;
    logic            pop;

    assign full = (count == FULL_COUNT);
    assign push = map_valid && !full;  // Newest event dropped when full
    assign pop  = key_next && key_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
            if (map_valid && full) begin
                overflow <= 1'b1; // Sticky
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {map_code, map_ascii, map_release, map_extended};
        end
    end

    assign key_ready = (count != '0);
    assign {key_code, key_ascii, key_release, key_extended} = mem[rd_ptr]; // Head entry

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst) count <= FULL_COUNT
    );

endmodule

/* source/keyboard_top.sv */
`timescale 1ns/1ps
`include "kbd_params.svh"

module keyboard_top import ps2_pkg::*, key_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       key_next,
    output scan_code_t key_code,
    output ascii_t     key_ascii,
    output logic       key_release,
    output logic       key_extended,
    output logic       key_ready,
    output logic       overflow,
    output logic       frame_error
);

    scan_code_t code;
    logic       code_valid;
    scan_code_t ev_code;
    logic       ev_release;
    logic       ev_extended;
    logic       ev_valid;
    scan_code_t map_code;
    ascii_t     map_ascii;
    logic       map_release;
    logic       map_extended;
    logic       map_valid;

    ps2_frame_rx ps2_frame_rx_inst (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .code        (code),
        .code_valid  (code_valid),
        .frame_error (frame_error)
    );

    key_event_decoder key_event_decoder_inst (
        .clk         (clk),
        .rst         (rst),
        .code        (code),
        .code_valid  (code_valid),
        .ev_code     (ev_code),
        .ev_release  (ev_release),
        .ev_extended (ev_extended),
        .ev_valid    (ev_valid)
    );

    ascii_map ascii_map_inst (
        .clk          (clk),
        .rst          (rst),
        .ev_code      (ev_code),
        .ev_release   (ev_release),
        .ev_extended  (ev_extended),
        .ev_valid     (ev_valid),
        .map_code     (map_code),
        .map_ascii    (map_ascii),
        .map_release  (map_release),
        .map_extended (map_extended),
        .map_valid    (map_valid)
    );

    key_fifo #(
        .DEPTH (`KBD_FIFO_DEPTH)
    ) key_fifo_inst (
        .clk          (clk),
        .rst          (rst),
        .map_code     (map_code),
        .map_ascii    (map_ascii),
        .map_release  (map_release),
        .map_extended (map_extended),
        .map_valid    (map_valid),
        .key_next     (key_next),
        .key_code     (key_code),
        .key_ascii    (key_ascii),
        .key_release  (key_release),
        .key_extended (key_extended),
        .key_ready    (key_ready),
        .overflow     (overflow)
    );

endmodule

/* testbench/keyboard_tb.sv */
`timescale 1ns/1ps

module keyboard_tb;

    localparam int CLKS_PER_LINE = 300; // Watchdog budget per stim line
    localparam int PS2_HALF      = 8;   // clk cycles per PS/2 half period
    localparam int READY_WAIT    = 400; // Longest wait for one key event
    localparam int IDLE_CLKS     = 40;

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    logic       key_next;
    logic [7:0] key_code;
    logic [7:0] key_ascii;
    logic       key_release;
    logic       key_extended;
    logic       key_ready;
    logic       overflow;
    logic       frame_error;

    int errors     = 0;
    int checks     = 0;
    int stim_lines = 0;

    keyboard_top keyboard_top_inst (
        .clk          (clk),
        .rst          (rst),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .key_next     (key_next),
        .key_code     (key_code),
        .key_ascii    (key_ascii),
        .key_release  (key_release),
        .key_extended (key_extended),
        .key_ready    (key_ready),
        .overflow     (overflow),
        .frame_error  (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task check_value(input string name, input logic [7:0] expected, input logic [7:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR: %s expected %h got %h", name, expected, actual);
        end
    endtask

    task report_bad_line(input logic [7:0] cmd);
        errors++;
        $display("Stimulus line for command %c has missing fields", cmd);
    endtask

    // Frame is start, 8 data bits LSB first, odd parity, stop
    task send_frame(input logic [7:0] value, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_data <= bits[i]; // Changes while ps2_clk is high
            repeat (PS2_HALF / 2 - 1) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (PS2_HALF) @(posedge clk);
            ps2_clk <= 1'b1;
            repeat (PS2_HALF / 2) @(posedge clk);
        end
    endtask

    // Wait for the head event, compare it, then pop it
    task read_event(input logic [7:0] exp_code, input logic [7:0] exp_ascii,
                    input logic exp_release, input logic exp_extended);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!key_ready && waited < READY_WAIT) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (key_ready) else begin
            errors++;
            $display("No key event arrived within %0d clock cycles", READY_WAIT);
        end
        if (key_ready) begin
            check_value("key_code", exp_code, key_code);
            check_value("key_ascii", exp_ascii, key_ascii);
            check_value("key_release", exp_release, key_release);
            check_value("key_extended", exp_extended, key_extended);
            @(posedge clk);
            key_next <= 1'b1;
            @(posedge clk);
            key_next <= 1'b0;
        end
    endtask

    task expect_idle();
        repeat (IDLE_CLKS) @(posedge clk);
        @(negedge clk);
        check_value("key_ready", 1'b0, key_ready);
    endtask

    initial begin
        int         fd;
        int         got;
        logic [7:0] cmd;
        logic [7:0] arg_a;
        logic [7:0] arg_b;
        logic [7:0] arg_c;
        logic [7:0] arg_d;
        logic [8*128-1:0] line_buf;
        rst      = 1'b1;
        ps2_clk  = 1'b1; // Both lines idle high
        ps2_data = 1'b1;
        key_next = 1'b0;
        fd = $fopen("testbench/keyboard_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the stimulus file testbench/keyboard_stim.txt");
        end else begin
            while ($fgets(line_buf, fd) != 0) begin
                stim_lines++;
            end
            $fclose(fd);
            fd = $fopen("testbench/keyboard_stim.txt", "r");
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        if (fd != 0) begin
            while ($fscanf(fd, " %c", cmd) == 1) begin
                case (cmd)
                    "#": got = $fgets(line_buf, fd); // Comment line
                    "S", "P": begin
                        got = $fscanf(fd, "%h", arg_a);
                        if (got != 1) report_bad_line(cmd);
                        else send_frame(arg_a, cmd == "P");
                    end
                    "R": begin
                        got = $fscanf(fd, "%h %h %h %h", arg_a, arg_b, arg_c, arg_d);
                        if (got != 4) report_bad_line(cmd);
                        else read_event(arg_a, arg_b, arg_c[0], arg_d[0]);
                    end
                    "F", "O": begin
                        got = $fscanf(fd, "%h", arg_a);
                        @(negedge clk);
                        if (got != 1) report_bad_line(cmd);
                        else if (cmd == "F") check_value("frame_error", arg_a, frame_error);
                        else check_value("overflow", arg_a, overflow);
                    end
                    "E": expect_idle();
                    default: begin
                        errors++;
                        $display("Unknown stimulus command %c", cmd);
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Budget scales with the number of stim lines
    initial begin
        wait (stim_lines != 0);
        repeat (stim_lines * CLKS_PER_LINE + 8) @(posedge clk);
        errors++;
        $display("Watchdog timeout, stimulus not finished after %0d clock cycles",
                 stim_lines * CLKS_PER_LINE + 8);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* all.f */
+incdir+common
common/ps2_pkg.sv
common/key_pkg.sv
ps2_rx/ps2_frame_rx.sv
source/key_event_decoder.sv
source/ascii_map.sv
source/key_fifo.sv
source/keyboard_top.sv
testbench/keyboard_tb.sv

/* testbench/keyboard_stim.txt */
# S byte / P byte: send a good / wrong-parity frame; E: no event pending after idle
# R code ascii release extended: read one event; F flag / O flag: frame_error / overflow
S 1C
R 1C 41 0 0
S 45
R 45 30 0 0
S F0
E
S 1C
R 1C 41 1 0
S E0
S 75
R 75 00 0 1
S E0
S F0
S 75
R 75 00 1 1
F 0
P 1C
E
F 1
S 32
R 32 42 0 0
S 05
R 05 00 0 0
O 0
S 16
S 1E
S 26
S 25
S 2E
S 36
S 3D
S 3E
S 46
O 1
R 16 31 0 0
R 1E 32 0 0
R 26 33 0 0
R 25 34 0 0
R 2E 35 0 0
R 36 36 0 0
R 3D 37 0 0
R 3E 38 0 0
E
